// File: video_bus_stimulus.txt
# Columns: command, then hex arguments. Addresses are VRAM word addresses.
# W addr data | E addr | S | R addr expected_data | B count (count R lines follow)
W 010 11110000
W 011 22220001
S
R 010 11110000
R 011 22220001
E 010
R 010 11110000
W 020 a0000020
W 021 a0000021
W 022 a0000022
W 023 a0000023
W 024 a0000024
W 025 a0000025
W 026 a0000026
W 027 a0000027
W 010 3333beef
W 028 a0000028
W 029 a0000029
W 02a a000002a
W 02b a000002b
W 02c a000002c
W 02d a000002d
W 02e a000002e
W 02f a000002f
W 030 a0000030
S
B 8
R 020 a0000020
R 025 a0000025
R 010 3333beef
R 030 a0000030
R 011 22220001
R 02a a000002a
R 027 a0000027
R 02f a000002f
E 011
W 040 5555cafe
S
R 040 5555cafe
R 011 22220001

// File: verilog.f
+incdir+.
video_bus_pkg.sv
sync_fifo.sv
cpu_apb_port.sv
vram_arbiter.sv
vram_model.sv
video_bus_top.sv
tb_video_bus.sv

// File: Makefile
# Verilator flow for the video memory bus.
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP ?= tb_video_bus
DUT_TOP ?= video_bus_top
FILELIST ?= verilog.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing
PASS_TEXT ?= TB PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(DUT_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_video_bus.sv
`default_nettype none

`include "video_bus_defs.svh"

module tb_video_bus import video_bus_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	logic i_clock;
	logic i_rst;
	logic i_psel;
	logic i_penable;
	logic i_pwrite;
	logic [`VB_ADDR_BITS+1:0] i_paddr;
	logic [`VB_DATA_BITS-1:0] i_pwdata;
	logic o_pready;
	logic o_pslverr;
	logic i_video_req;
	logic [`VB_ADDR_BITS-1:0] i_video_addr;
	logic o_video_ack;
	video_word_t o_video_word;
	logic o_video_valid;
	logic i_video_ready;
	logic o_wq_idle;

	// Words requested but not yet seen by the consumer, oldest first.
	video_word_t exp_q[$];
	logic [31:0] rand_state = 32'h9207;
	int limit_cycles = 0;

	video_bus_top video_bus_top_i (.*);

	always begin
		i_clock = 1'b0;
		#10;
		i_clock = 1'b1;
		#10;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic abort_run();
		$display("TB FAILED");
		$fatal(1, "Stopping at the first error.");
	endtask

	task automatic check_video_word(input video_word_t got, input video_word_t exp);
		if (got !== exp) begin
			$display("FAILED time=%0t o_video_word got data=%h addr=%h expected data=%h addr=%h",
				$time, got.data, got.addr, exp.data, exp.addr);
			abort_run();
		end
	endtask

	task automatic check_apb_resp(input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAILED time=%0t o_pslverr got %b expected %b", $time, got, exp);
			abort_run();
		end
	endtask

	task automatic check_idle(input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAILED time=%0t o_wq_idle got %b expected %b", $time, got, exp);
			abort_run();
		end
	endtask

	// One APB transfer; waits out back-pressure in the access phase.
	task automatic apb_access(input logic write, input logic [`VB_ADDR_BITS-1:0] addr,
			input logic [`VB_DATA_BITS-1:0] data, input logic exp_err);
		@(negedge i_clock);
		i_psel = 1'b1;
		i_penable = 1'b0;
		i_pwrite = write;
		i_paddr = {addr, 2'b00};
		i_pwdata = data;
		@(negedge i_clock);
		i_penable = 1'b1;
		#1;
		while (!o_pready) begin
			@(negedge i_clock);
			#1;
		end
		check_apb_resp(o_pslverr, exp_err);
		@(negedge i_clock);
		i_psel = 1'b0;
		i_penable = 1'b0;
		// A posted write must show as pending right after it lands.
		if (write)
			check_idle(o_wq_idle, 1'b0);
	endtask

	task automatic video_request(input logic [`VB_ADDR_BITS-1:0] addr,
			input logic [`VB_DATA_BITS-1:0] data);
		video_word_t exp;
		exp.data = data;
		exp.addr = addr;
		@(negedge i_clock);
		i_video_req = 1'b1;
		i_video_addr = addr;
		#1;
		while (!o_video_ack) begin
			@(negedge i_clock);
			#1;
		end
		exp_q.push_back(exp);
		@(negedge i_clock);
		i_video_req = 1'b0;
	endtask

	task automatic drain_words();
		while (exp_q.size() != 0)
			@(negedge i_clock);
	endtask

	task automatic wait_idle();
		@(negedge i_clock);
		while (!o_wq_idle)
			@(negedge i_clock);
	endtask

	// Consumer with random stalls; a word is taken on the next rising edge.
	initial begin : consumer
		forever begin
			@(negedge i_clock);
			rand_state = lcg_next(rand_state);
			i_video_ready = (rand_state[17:16] != 2'b00);
			#1;
			if (!i_rst && o_video_valid && i_video_ready) begin
				if (exp_q.size() == 0) begin
					$display("A video word arrived at %0t with no request outstanding.", $time);
					abort_run();
				end
				check_video_word(o_video_word, exp_q.pop_front());
			end
		end
	end

	initial begin : watchdog
		wait (limit_cycles != 0);
		repeat (limit_cycles) @(posedge i_clock);
		$display("The run timed out with no DUT progress after %0d cycles.", limit_cycles);
		abort_run();
	end

	initial begin : main
		int fd;
		int idx;
		int n;
		string line;
		string lines[$];
		byte cmd;
		logic [31:0] arg_a;
		logic [31:0] arg_b;
		logic have_r;
		logic [`VB_ADDR_BITS-1:0] last_r_addr;
		logic [`VB_DATA_BITS-1:0] last_r_data;

		i_rst = 1'b1;
		i_psel = 1'b0;
		i_penable = 1'b0;
		i_pwrite = 1'b0;
		i_paddr = '0;
		i_pwdata = '0;
		i_video_req = 1'b0;
		i_video_addr = '0;
		i_video_ready = 1'b0;
		have_r = 1'b0;
		last_r_addr = '0;
		last_r_data = '0;

		fd = $fopen("video_bus_stimulus.txt", "r");
		if (fd == 0) begin
			$display("Could not open video_bus_stimulus.txt.");
			abort_run();
		end
		// Keep command lines only; comments and blanks start below 'A'.
		while (!$feof(fd)) begin
			line = "";
			if ($fgets(line, fd) != 0 && line.len() > 0 && line.getc(0) >= "A")
				lines.push_back(line);
		end
		$fclose(fd);
		limit_cycles = 200 * lines.size() + 1000;

		repeat (8) @(negedge i_clock);
		i_rst = 1'b0;
		@(negedge i_clock);
		check_idle(o_wq_idle, 1'b1);

		idx = 0;
		while (idx < lines.size()) begin
			cmd = lines[idx].getc(0);
			void'($sscanf(lines[idx].substr(1, lines[idx].len() - 1), "%h %h", arg_a, arg_b));
			case (cmd)
				"W": begin
					// A write to the re-read word would race its own read.
					if (have_r && arg_a[`VB_ADDR_BITS-1:0] == last_r_addr)
						have_r = 1'b0;
					if (have_r) begin
						// A video read competes with each write, so the queue backs up.
						fork
							apb_access(1'b1, arg_a[`VB_ADDR_BITS-1:0], arg_b, 1'b0);
							video_request(last_r_addr, last_r_data);
						join
					end else begin
						apb_access(1'b1, arg_a[`VB_ADDR_BITS-1:0], arg_b, 1'b0);
					end
				end
				"E": apb_access(1'b0, arg_a[`VB_ADDR_BITS-1:0], '0, 1'b1);
				"S": wait_idle();
				"R": begin
					video_request(arg_a[`VB_ADDR_BITS-1:0], arg_b);
					drain_words();
					have_r = 1'b1;
					last_r_addr = arg_a[`VB_ADDR_BITS-1:0];
					last_r_data = arg_b;
				end
				"B": begin
					n = arg_a;
					// Requests go out back to back and drain together.
					repeat (n) begin
						idx++;
						if (idx >= lines.size() || lines[idx].getc(0) != "R") begin
							$display("A B block is not followed by enough R lines.");
							abort_run();
						end
						void'($sscanf(lines[idx].substr(1, lines[idx].len() - 1), "%h %h",
							arg_a, arg_b));
						video_request(arg_a[`VB_ADDR_BITS-1:0], arg_b);
						have_r = 1'b1;
						last_r_addr = arg_a[`VB_ADDR_BITS-1:0];
						last_r_data = arg_b;
					end
					drain_words();
				end
				default: begin
					$display("Unknown stimulus command in line: %s", lines[idx]);
					abort_run();
				end
			endcase
			idx++;
		end
		drain_words();

		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: video_bus_top.sv
`default_nettype none

`include "video_bus_defs.svh"

module video_bus_top import video_bus_pkg::*; (
	input wire logic i_clock,
	input wire logic i_rst,
	// APB completer.
	input wire logic i_psel,
	input wire logic i_penable,
	input wire logic i_pwrite,
	input wire logic [`VB_ADDR_BITS+1:0] i_paddr,
	input wire logic [`VB_DATA_BITS-1:0] i_pwdata,
	output logic o_pready,
	output logic o_pslverr,
	// Scan-out client.
	input wire logic i_video_req,
	input wire logic [`VB_ADDR_BITS-1:0] i_video_addr,
	output logic o_video_ack,
	output video_word_t o_video_word,
	output logic o_video_valid,
	input wire logic i_video_ready,
	// Status.
	output logic o_wq_idle
);

	logic wq_full;
	logic wq_push;
	vram_write_t wq_data;
	logic wq_empty;
	vram_write_t wq_head;
	logic wq_pop;
	vram_cmd_t cmd;
	logic mem_ready;
	logic [`VB_DATA_BITS-1:0] mem_rdata;
	logic [$clog2(`VB_RQ_DEPTH+1)-1:0] rq_count;
	logic rq_push;
	video_word_t rq_data;
	logic rq_empty;

	cpu_apb_port cpu_apb_port_i (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_psel(i_psel),
		.i_penable(i_penable),
		.i_pwrite(i_pwrite),
		.i_paddr(i_paddr),
		.i_pwdata(i_pwdata),
		.o_pready(o_pready),
		.o_pslverr(o_pslverr),
		.i_wq_full(wq_full),
		.o_wq_push(wq_push),
		.o_wq_data(wq_data)
	);

	sync_fifo #(
		.payload_t(vram_write_t),
		.DEPTH(`VB_WQ_DEPTH)
	) write_queue_i (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_push(wq_push),
		.i_data(wq_data),
		.i_pop(wq_pop),
		.o_head(wq_head),
		.o_empty(wq_empty),
		.o_full(wq_full),
		.o_count()
	);

	vram_arbiter vram_arbiter_i (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_video_req(i_video_req),
		.i_video_addr(i_video_addr),
		.o_video_ack(o_video_ack),
		.i_wq_empty(wq_empty),
		.i_wq_head(wq_head),
		.o_wq_pop(wq_pop),
		.o_cmd(cmd),
		.i_mem_ready(mem_ready),
		.i_mem_rdata(mem_rdata),
		.i_rq_count(rq_count),
		.o_rq_push(rq_push),
		.o_rq_data(rq_data),
		.o_wq_idle(o_wq_idle)
	);

	vram_model vram_model_i (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_cmd(cmd),
		.o_ready(mem_ready),
		.o_rdata(mem_rdata)
	);

	// Pop is ignored while empty, so ready can drive it directly.
	sync_fifo #(
		.payload_t(video_word_t),
		.DEPTH(`VB_RQ_DEPTH)
	) return_queue_i (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_push(rq_push),
		.i_data(rq_data),
		.i_pop(i_video_ready),
		.o_head(o_video_word),
		.o_empty(rq_empty),
		.o_full(),
		.o_count(rq_count)
	);

	assign o_video_valid = !rq_empty;

endmodule

`default_nettype wire

// File: vram_model.sv
`default_nettype none

`include "video_bus_defs.svh"

module vram_model import video_bus_pkg::*; (
	input wire logic i_clock,
	input wire logic i_rst,
	input wire vram_cmd_t i_cmd,
	output logic o_ready,
	output logic [`VB_DATA_BITS-1:0] o_rdata
);

	localparam int LAT = `VB_VRAM_LATENCY;
	localparam int WORDS = 2 ** `VB_ADDR_BITS;

	logic [`VB_DATA_BITS-1:0] mem [WORDS];
	vram_cmd_t pipe [LAT];
	vram_cmd_t cmd_out;

	// Command at the end of the delay line.
	assign cmd_out = pipe[LAT-1];

	assign o_ready = cmd_out.valid;
	assign o_rdata = mem[cmd_out.addr];

	// Delay line; only the valid bits are cleared.
	always_ff @(posedge i_clock) begin
		pipe[0] <= i_cmd;
		for (int i = 1; i < LAT; i++)
			pipe[i] <= pipe[i-1];
		if (i_rst) begin
			for (int i = 0; i < LAT; i++)
				pipe[i].valid <= 1'b0;
		end
	end

	// Write lands when the command leaves the line.
	always_ff @(posedge i_clock) begin
		if (cmd_out.valid && cmd_out.rw)
			mem[cmd_out.addr] <= cmd_out.wdata;
	end

endmodule

`default_nettype wire

// File: vram_arbiter.sv
`default_nettype none

`include "video_bus_defs.svh"

module vram_arbiter import video_bus_pkg::*; (
	input wire logic i_clock,
	input wire logic i_rst,
	input wire logic i_video_req,
	input wire logic [`VB_ADDR_BITS-1:0] i_video_addr,
	output logic o_video_ack,
	input wire logic i_wq_empty,
	input wire vram_write_t i_wq_head,
	output logic o_wq_pop,
	output vram_cmd_t o_cmd,
	input wire logic i_mem_ready,
	input wire logic [`VB_DATA_BITS-1:0] i_mem_rdata,
	input wire logic [$clog2(`VB_RQ_DEPTH+1)-1:0] i_rq_count,
	output logic o_rq_push,
	output video_word_t o_rq_data,
	output logic o_wq_idle
);

	localparam int RQ_CNT_BITS = $clog2(`VB_RQ_DEPTH + 1);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_READ_WAIT,
		ST_WRITE_WAIT
	} state_t;

	state_t state;
	logic [`VB_ADDR_BITS-1:0] read_addr;
	logic [RQ_CNT_BITS:0] rq_used;
	logic rq_space;
	logic take_read;
	logic take_write;

	// A word still waiting to be pushed holds its slot too.
	assign rq_used = {1'b0, i_rq_count} + {{RQ_CNT_BITS{1'b0}}, o_rq_push};
	assign rq_space = rq_used < (RQ_CNT_BITS + 1)'(`VB_RQ_DEPTH);

	// Video first, writes only when no video request is pending.
	assign take_read = (state == ST_IDLE) && i_video_req && rq_space;
	assign take_write = (state == ST_IDLE) && !i_video_req && !i_wq_empty;

	assign o_video_ack = take_read;
	assign o_wq_pop = take_write;
	assign o_wq_idle = i_wq_empty && (state != ST_WRITE_WAIT);

	// Command is issued in the cycle of the decision.
	always_comb begin
		o_cmd = '0;
		if (take_read) begin
			o_cmd.valid = 1'b1;
			o_cmd.rw = 1'b0;
			o_cmd.addr = i_video_addr;
		end else if (take_write) begin
			o_cmd.valid = 1'b1;
			o_cmd.rw = 1'b1;
			o_cmd.addr = i_wq_head.addr;
			o_cmd.wdata = i_wq_head.data;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			state <= ST_IDLE;
			o_rq_push <= 1'b0;
		end else begin
			o_rq_push <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (take_read)
						state <= ST_READ_WAIT;
					else if (take_write)
						state <= ST_WRITE_WAIT;
				end
				ST_READ_WAIT: begin
					if (i_mem_ready) begin
						o_rq_push <= 1'b1;
						state <= ST_IDLE;
					end
				end
				ST_WRITE_WAIT: begin
					if (i_mem_ready)
						state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Word and address leave together.
	always_ff @(posedge i_clock) begin
		if (take_read)
			read_addr <= i_video_addr;
		if (state == ST_READ_WAIT && i_mem_ready) begin
			o_rq_data.data <= i_mem_rdata;
			o_rq_data.addr <= read_addr;
		end
	end

endmodule

`default_nettype wire

// File: cpu_apb_port.sv
`default_nettype none

`include "video_bus_defs.svh"

module cpu_apb_port import video_bus_pkg::*; (
	input wire logic i_clock,
	input wire logic i_rst,
	input wire logic i_psel,
	input wire logic i_penable,
	input wire logic i_pwrite,
	input wire logic [`VB_ADDR_BITS+1:0] i_paddr,
	input wire logic [`VB_DATA_BITS-1:0] i_pwdata,
	output logic o_pready,
	output logic o_pslverr,
	input wire logic i_wq_full,
	output logic o_wq_push,
	output vram_write_t o_wq_data
);

	logic setup_seen;
	logic access;

	// Tracks the setup phase, so an access phase is served once per transfer.
	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			setup_seen <= 1'b0;
		end else if (!i_psel) begin
			setup_seen <= 1'b0;
		end else if (!i_penable) begin
			setup_seen <= 1'b1;
		end else if (o_pready) begin
			setup_seen <= 1'b0;
		end
	end

	assign access = i_psel && i_penable && setup_seen;

	// Writes wait while the queue is full; reads finish at once.
	assign o_pready = access && (!i_pwrite || !i_wq_full);

	// No CPU read path to VRAM.
	assign o_pslverr = access && !i_pwrite;

	assign o_wq_push = access && i_pwrite && !i_wq_full;

	// Byte address to word address.
	assign o_wq_data.addr = i_paddr[`VB_ADDR_BITS+1:2];
	assign o_wq_data.data = i_pwdata;

endmodule

`default_nettype wire

// File: sync_fifo.sv
`default_nettype none

module sync_fifo #(
	parameter type payload_t = logic [31:0],
	parameter int DEPTH = 4
) (
	input wire logic i_clock,
	input wire logic i_rst,
	input wire logic i_push,
	input wire payload_t i_data,
	input wire logic i_pop,
	output payload_t o_head,
	output logic o_empty,
	output logic o_full,
	output logic [$clog2(DEPTH+1)-1:0] o_count
);

	localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_BITS = $clog2(DEPTH + 1);

	payload_t mem [DEPTH];
	logic [PTR_BITS-1:0] rd_ptr;
	logic [PTR_BITS-1:0] wr_ptr;
	logic [CNT_BITS-1:0] count;
	logic do_push;
	logic do_pop;

	assign o_empty = (count == '0);
	assign o_full = (count == CNT_BITS'(DEPTH));
	assign o_count = count;

	// Head comes straight from storage, no read latency.
	assign o_head = mem[rd_ptr];

	assign do_push = i_push && !o_full;
	assign do_pop = i_pop && !o_empty;

	function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
		if (ptr == PTR_BITS'(DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	always_ff @(posedge i_clock) begin
		if (do_push)
			mem[wr_ptr] <= i_data;
	end

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_pop)
				rd_ptr <= next_ptr(rd_ptr);
			// Simultaneous push and pop leaves the count alone.
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: video_bus_pkg.sv
`default_nettype none

`include "video_bus_defs.svh"

package video_bus_pkg;

	// One posted CPU write, as held in the write queue.
	typedef struct packed {
		logic [`VB_ADDR_BITS-1:0] addr;
		logic [`VB_DATA_BITS-1:0] data;
	} vram_write_t;

	// Command from the arbiter to VRAM.
	// rw is 1 for a write, 0 for a read.
	typedef struct packed {
		logic                     valid;
		logic                     rw;
		logic [`VB_ADDR_BITS-1:0] addr;
		logic [`VB_DATA_BITS-1:0] wdata;
	} vram_cmd_t;

	// Word returned to the scan-out client, tagged with its address.
	typedef struct packed {
		logic [`VB_DATA_BITS-1:0] data;
		logic [`VB_ADDR_BITS-1:0] addr;
	} video_word_t;

endpackage

`default_nettype wire

// File: video_bus_defs.svh
`ifndef VIDEO_BUS_DEFS_SVH
`define VIDEO_BUS_DEFS_SVH

// Word address into VRAM.
// The APB byte address is two bits wider.
`define VB_ADDR_BITS 12

// One pixel word.
`define VB_DATA_BITS 32

// Posted CPU writes waiting for a VRAM slot.
`define VB_WQ_DEPTH 8

// Read words waiting for the scan-out client.
// Video reads are only accepted while a slot is free here.
`define VB_RQ_DEPTH 4

// Cycles from a VRAM command to its ready pulse.
`define VB_VRAM_LATENCY 2

`endif
